/* rv_core.f */
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_load_store_unit.sv
verilog/rv_core.sv
test/tb_clock_gen.sv
test/tb_data_mem.sv
test/tb_rv_core.sv

/* test/rv_core_stim.txt */
// rv_core stimulus, all values hex
// header: program_words memory_words store_records trace_length halt_pc
23 1 11 20 80000088
// program words from 80000000
123450b7 67808093 10102023 00001117 10202223 00c001ef 00100073 00100073
10302423 01518267 00100073 10402623 20002303 10602823 20000303 10602a23
20104303 10602c23 20200303 10602e23 20304303 12602023 20300303 12602223
20001303 12602423 20201303 12602623 20205303 12602823 141000a3 14101123
141001a3 14101223 00100073
// memory image: addr data
00000200 8c7f05f1
// store records: addr wdata wmask
00000100 12345678 f  00000104 8000100c f  00000108 80000018 f
0000010c 80000028 f  00000110 8c7f05f1 f  00000114 fffffff1 f
00000118 00000005 f  0000011c 0000007f f  00000120 0000008c f
00000124 ffffff8c f  00000128 000005f1 f  0000012c ffff8c7f f
00000130 00008c7f f  00000141 34567800 2  00000142 56780000 c
00000143 78000000 8  00000144 12345678 3
// pc trace, one per retired instruction, ending at the halt pc
80000000 80000004 80000008 8000000c 80000010 80000014 80000020 80000024
8000002c 80000030 80000034 80000038 8000003c 80000040 80000044 80000048
8000004c 80000050 80000054 80000058 8000005c 80000060 80000064 80000068
8000006c 80000070 80000074 80000078 8000007c 80000080 80000084 80000088

/* test/tb_rv_core.sv */
`timescale 1ns/1ps

`include "rv_core_macros.svh"

module tb_rv_core;
  import rv_pkg::*;

  localparam int          max_words   = 64;
  localparam int          drive_delay = 1;
  localparam logic [31:0] rand_seed   = 32'h5342_38b4;

  logic             clk;
  logic             arst_n;
  logic [`XLEN-1:0] inst;
  logic [`XLEN-1:0] pc;
  dmem_req_t        dmem_req;
  logic             dmem_req_valid;
  logic             dmem_ack;
  logic [`XLEN-1:0] dmem_rdata;
  logic             halt;
  logic             proto_error;

  logic [31:0] stim [0:255];
  logic [31:0] prog [max_words];
  logic [31:0] st_addr [max_words];
  logic [31:0] st_wdata [max_words];
  logic [31:0] st_wmask [max_words];
  logic [31:0] trace [max_words];
  logic [31:0] halt_pc;
  logic [31:0] last_pc;
  logic        stim_loaded;
  logic        prev_req_valid;
  int          n_prog;
  int          n_store;
  int          n_trace;
  int          n_mem_ops;
  int          store_idx;
  int          trace_idx;

  tb_clock_gen #(.period_ns(100), .reset_cycles(8)) u_clock_gen (.clk(clk), .arst_n(arst_n));

  rv_core u_rv_core (
    .clk            (clk),
    .arst_n         (arst_n),
    .inst           (inst),
    .pc             (pc),
    .dmem_req       (dmem_req),
    .dmem_req_valid (dmem_req_valid),
    .dmem_ack       (dmem_ack),
    .dmem_rdata     (dmem_rdata),
    .halt           (halt)
  );

  tb_data_mem #(.seed(rand_seed)) u_data_mem (
    .clk            (clk),
    .arst_n         (arst_n),
    .dmem_req       (dmem_req),
    .dmem_req_valid (dmem_req_valid),
    .dmem_ack       (dmem_ack),
    .dmem_rdata     (dmem_rdata),
    .proto_error    (proto_error)
  );

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  function automatic logic [31:0] fetch(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - `RESET_PC) >> 2;
    return (idx < n_prog) ? prog[idx] : 32'h0;  // outside the program reads a no-op
  endfunction

  task automatic load_stim();
    int p;
    int n_mem;
    $readmemh("test/rv_core_stim.txt", stim);
    if (stim[0] === 'x) begin
      $display("stim file test/rv_core_stim.txt could not be read");
      abort_run();
    end
    n_prog    = stim[0];
    n_mem     = stim[1];
    n_store   = stim[2];
    n_trace   = stim[3];
    halt_pc   = stim[4];
    n_mem_ops = 0;
    p = 5;
    for (int i = 0; i < n_prog; i++) begin
      prog[i] = stim[p + i];
      if (prog[i][6:0] inside {7'h03, 7'h23}) n_mem_ops++;  // loads and stores
    end
    p = p + n_prog;
    for (int i = 0; i < n_mem; i++) begin
      u_data_mem.load_word(stim[p + 2*i], stim[p + 2*i + 1]);
    end
    p = p + 2 * n_mem;
    for (int i = 0; i < n_store; i++) begin
      st_addr[i]  = stim[p + 3*i];
      st_wdata[i] = stim[p + 3*i + 1];
      st_wmask[i] = stim[p + 3*i + 2];
    end
    p = p + 3 * n_store;
    for (int i = 0; i < n_trace; i++) begin
      trace[i] = stim[p + i];
    end
  endtask

  always @(posedge clk) begin
    #drive_delay;
    inst = fetch(pc);
  end

  // store requests are checked once as req rises
  always @(posedge clk) begin
    if (stim_loaded && arst_n && dmem_req_valid && !prev_req_valid && dmem_req.write) begin
      if (store_idx >= n_store) begin
        check_value("number of stores", store_idx + 1, n_store);
      end else begin
        check_value("store addr", dmem_req.addr, st_addr[store_idx]);
        check_value("store wdata", dmem_req.wdata, st_wdata[store_idx]);
        check_value("store wmask", {28'h0, dmem_req.wmask}, st_wmask[store_idx]);
      end
      store_idx++;
    end
    prev_req_valid = dmem_req_valid;
  end

  // one pc trace entry each time pc moves
  always @(posedge clk) begin
    if (stim_loaded && arst_n && (trace_idx == 0 || pc !== last_pc)) begin
      if (trace_idx < n_trace) begin
        check_value("pc trace", pc, trace[trace_idx]);
      end else begin
        check_value("pc past end of trace", pc, last_pc);
      end
      trace_idx++;
      last_pc = pc;
    end
  end

  always @(posedge proto_error) begin
    abort_run();
  end

  initial begin : watchdog
    int unsigned budget;
    wait (stim_loaded === 1'b1);
    budget = 20 * n_prog + 10 * n_mem_ops + 8 + 10;  // reset and halt tail on top
    repeat (budget) @(posedge clk);
    $display("watchdog expired after %0d cycles, the core never halted", budget);
    abort_run();
  end

  initial begin
    inst           = '0;
    stim_loaded    = 1'b0;
    prev_req_valid = 1'b0;
    store_idx      = 0;
    trace_idx      = 0;
    last_pc        = '0;
    load_stim();
    stim_loaded = 1'b1;

    repeat (4) @(posedge clk);
    check_value("pc in reset", pc, `RESET_PC);
    check_value("req in reset", {31'b0, dmem_req_valid}, 32'h0);
    check_value("halt in reset", {31'b0, halt}, 32'h0);
    wait (arst_n === 1'b1);
    @(posedge clk);
    check_value("pc after reset", pc, `RESET_PC);
    check_value("req after reset", {31'b0, dmem_req_valid}, 32'h0);
    check_value("halt after reset", {31'b0, halt}, 32'h0);

    wait (halt === 1'b1);
    check_value("pc at halt", pc, halt_pc);
    repeat (10) begin
      @(posedge clk);
      check_value("pc after halt", pc, halt_pc);
      check_value("req after halt", {31'b0, dmem_req_valid}, 32'h0);
      check_value("halt held", {31'b0, halt}, 32'h1);
    end
    check_value("stores seen", store_idx, n_store);
    check_value("pc trace length", trace_idx, n_trace);
    $display("Regression passed");
    $finish;
  end

endmodule

/* test/tb_data_mem.sv */
`timescale 1ns/1ps

module tb_data_mem #(
  parameter logic [31:0] seed = 32'h1
) (
  input  logic              clk,
  input  logic              arst_n,
  input  rv_pkg::dmem_req_t dmem_req,
  input  logic              dmem_req_valid,
  output logic              dmem_ack,
  output logic [31:0]       dmem_rdata,
  output logic              proto_error
);
  import rv_pkg::*;

  localparam int drive_delay = 1;

  logic [31:0] mem [logic [31:0]];  // keyed by word address

  task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
    mem[addr & ~32'h3] = data;
  endtask

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] key;
    key = addr & ~32'h3;
    if (mem.exists(key)) begin
      return mem[key];
    end
    return key ^ 32'h5a5a_a5a5;  // words never written
  endfunction

  task automatic write_lanes(input dmem_req_t req);
    logic [31:0] word;
    word = read_word(req.addr);
    for (int i = 0; i < 4; i++) begin
      if (req.wmask[i]) begin
        word[8*i +: 8] = req.wdata[8*i +: 8];
      end
    end
    mem[req.addr & ~32'h3] = word;
  endtask

  task automatic flag_protocol_error(input string msg);
    $display("protocol error at %0t ns: %s", $time, msg);
    proto_error = 1'b1;
  endtask

  // responder samples at each edge and drives just after it
  initial begin
    dmem_req_t   held;
    int unsigned delay;
    void'($urandom(seed));
    dmem_ack    = 1'b0;
    dmem_rdata  = '0;
    proto_error = 1'b0;
    forever begin
      @(posedge clk);
      if (arst_n && dmem_req_valid) begin
        held  = dmem_req;
        delay = $urandom_range(3, 0);
        repeat (delay) begin
          @(posedge clk);
          if (!dmem_req_valid || dmem_req !== held) begin
            flag_protocol_error("request changed or dropped before ack");
          end
        end
        #drive_delay;
        if (held.write) begin
          write_lanes(held);
        end else begin
          dmem_rdata = read_word(held.addr);
        end
        dmem_ack = 1'b1;
        @(posedge clk);
        while (dmem_req_valid) @(posedge clk);
        delay = $urandom_range(3, 0);  // hold ack a while after req drops
        repeat (delay) begin
          @(posedge clk);
          if (dmem_req_valid) begin
            flag_protocol_error("request raised again while ack was still high");
          end
        end
        #drive_delay dmem_ack = 1'b0;
      end
    end
  end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns    = 100,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 arst_n = 1'b1;  // release just after the edge
  end

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/1ps

`include "rv_core_macros.svh"

module rv_core (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [`XLEN-1:0]  inst,
  output logic [`XLEN-1:0]  pc,
  output rv_pkg::dmem_req_t dmem_req,
  output logic              dmem_req_valid,
  input  logic              dmem_ack,
  input  logic [`XLEN-1:0]  dmem_rdata,
  output logic              halt
);
  import rv_pkg::*;

  ctrl_t            ctrl;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] sum;
  logic [`XLEN-1:0] jump_target;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] next_pc;
  logic [`XLEN-1:0] wb_data;
  logic [`XLEN-1:0] load_data;
  logic             is_mem;
  logic             lsu_start;
  logic             lsu_done;
  logic             retire;
  logic             reg_we;

  rv_decoder u_decoder (
    .inst (inst),
    .ctrl (ctrl),
    .imm  (imm)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .we       (reg_we),
    .waddr    (ctrl.rd),
    .wdata    (wb_data),
    .rs1_addr (ctrl.rs1),
    .rs2_addr (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // shared adder for addresses, jump targets and arithmetic
  assign op_a        = ctrl.use_pc ? pc : rs1_data;
  assign sum         = op_a + imm;
  assign jump_target = ctrl.use_pc ? sum : {sum[`XLEN-1:1], 1'b0};  // jalr clears bit 0
  assign pc_plus4    = pc + 32'd4;
  assign next_pc     = ctrl.jump ? jump_target : pc_plus4;

  assign is_mem    = ctrl.mem_read || ctrl.mem_write;
  assign lsu_start = is_mem && !halt;

  rv_load_store_unit u_lsu (
    .clk            (clk),
    .arst_n         (arst_n),
    .start          (lsu_start),
    .ctrl           (ctrl),
    .addr           (sum),
    .store_data     (rs2_data),
    .dmem_req       (dmem_req),
    .dmem_req_valid (dmem_req_valid),
    .dmem_ack       (dmem_ack),
    .dmem_rdata     (dmem_rdata),
    .load_data      (load_data),
    .done           (lsu_done)
  );

  // memory ops wait for the handshake and ebreak never retires
  assign retire = !halt && !ctrl.halt && (!is_mem || lsu_done);
  assign reg_we = ctrl.reg_write && retire;

  always_comb begin
    case (ctrl.wb_sel)
      wb_link: wb_data = pc_plus4;
      wb_load: wb_data = load_data;
      default: wb_data = sum;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RESET_PC;
    end else if (retire) begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halt <= 1'b0;
    end else if (ctrl.halt) begin
      halt <= 1'b1;  // sticky until reset
    end
  end

endmodule

/* verilog/rv_load_store_unit.sv */
`timescale 1ns/1ps

`include "rv_core_macros.svh"

module rv_load_store_unit (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              start,
  input  rv_pkg::ctrl_t     ctrl,
  input  logic [`XLEN-1:0]  addr,
  input  logic [`XLEN-1:0]  store_data,
  output rv_pkg::dmem_req_t dmem_req,
  output logic              dmem_req_valid,
  input  logic              dmem_ack,
  input  logic [`XLEN-1:0]  dmem_rdata,
  output logic [`XLEN-1:0]  load_data,
  output logic              done
);
  import rv_pkg::*;

  lsu_state_e       state_q;
  lsu_state_e       state_d;
  dmem_req_t        req_d;
  dmem_req_t        req_q;
  mem_size_e        size_q;
  logic [`XLEN-1:0] rdata_q;
  logic [1:0]       lane;
  logic [3:0]       lane_mask;
  logic [7:0]       byte_sel;
  logic [15:0]      half_sel;

  assign lane = addr[1:0];

  // byte enables for naturally aligned accesses
  always_comb begin
    case (ctrl.mem_size)
      size_byte, size_byte_u: lane_mask = 4'b0001 << lane;
      size_half, size_half_u: lane_mask = 4'b0011 << lane;
      default:                lane_mask = 4'b1111;
    endcase
  end

  always_comb begin
    req_d.addr  = addr;
    req_d.wdata = store_data << {lane, 3'b000};  // move into its lane
    req_d.wmask = ctrl.mem_write ? lane_mask : 4'b0000;
    req_d.write = ctrl.mem_write;
  end

  // four-phase handshake
  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_idle: begin
        if (start) begin
          state_d = lsu_req;
        end
      end
      lsu_req: begin
        if (dmem_ack) begin
          state_d = lsu_wait_ack_low;  // req drops next cycle
        end
      end
      lsu_wait_ack_low: begin
        if (!dmem_ack) begin
          state_d = lsu_idle;
        end
      end
      default: state_d = lsu_idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= lsu_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // request fields held stable for the whole access
  always_ff @(posedge clk) begin
    if (state_q == lsu_idle && start) begin
      req_q  <= req_d;
      size_q <= ctrl.mem_size;
    end
    if (state_q == lsu_req && dmem_ack) begin
      rdata_q <= dmem_rdata;  // valid while ack is high
    end
  end

  assign dmem_req       = req_q;
  assign dmem_req_valid = (state_q == lsu_req);
  assign done           = (state_q == lsu_wait_ack_low) && !dmem_ack;

  // pick the addressed byte or halfword
  assign byte_sel = rdata_q[{req_q.addr[1:0], 3'b000} +: 8];
  assign half_sel = rdata_q[{req_q.addr[1], 4'b0000} +: 16];

  always_comb begin
    case (size_q)
      size_byte:   load_data = {{24{byte_sel[7]}}, byte_sel};
      size_half:   load_data = {{16{half_sel[15]}}, half_sel};
      size_byte_u: load_data = {24'h00_0000, byte_sel};
      size_half_u: load_data = {16'h0000, half_sel};
      default:     load_data = rdata_q;  // lw
    endcase
  end

endmodule

/* verilog/rv_regfile.sv */
`timescale 1ns/1ps

`include "rv_core_macros.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   we,
  input  logic [`REG_ADDR_W-1:0] waddr,
  input  logic [`XLEN-1:0]       wdata,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin  // x0 never written
      regs[waddr] <= wdata;
    end
  end

  // asynchronous read ports
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* verilog/rv_decoder.sv */
`timescale 1ns/1ps

`include "rv_core_macros.svh"

module rv_decoder (
  input  logic [`XLEN-1:0] inst,
  output rv_pkg::ctrl_t    ctrl,
  output logic [`XLEN-1:0] imm
);
  import rv_pkg::*;

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];

  // sign-extended immediates per format
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};  // already shifted
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl          = '0;
    ctrl.mem_size = mem_size_e'(funct3);
    ctrl.wb_sel   = wb_adder;
    ctrl.rd       = inst[11:7];
    ctrl.rs1      = inst[19:15];
    ctrl.rs2      = inst[24:20];
    imm           = imm_i;

    case (opcode)
      op_imm: begin
        if (funct3 == 3'b000) begin  // addi only
          ctrl.reg_write = 1'b1;
        end
      end
      op_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.rs1       = '0;  // x0 makes the adder pass imm
        imm            = imm_u;
      end
      op_auipc: begin
        ctrl.reg_write = 1'b1;
        ctrl.use_pc    = 1'b1;
        imm            = imm_u;
      end
      op_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.use_pc    = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.wb_sel    = wb_link;
        imm            = imm_j;
      end
      op_jalr: begin
        if (funct3 == 3'b000) begin
          ctrl.reg_write = 1'b1;
          ctrl.jump      = 1'b1;
          ctrl.wb_sel    = wb_link;
        end
      end
      op_load: begin
        // lb lh lw lbu lhu
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          ctrl.reg_write = 1'b1;
          ctrl.mem_read  = 1'b1;
          ctrl.wb_sel    = wb_load;
        end
      end
      op_store: begin
        imm = imm_s;
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin  // sb sh sw
          ctrl.mem_write = 1'b1;
        end
      end
      op_system: begin
        if (inst == 32'h0010_0073) begin  // ebreak
          ctrl.halt = 1'b1;
        end
      end
      default: begin
        // illegal opcode retires as a no-op
      end
    endcase
  end

endmodule

/* verilog/rv_pkg.sv */
package rv_pkg;

`include "rv_core_macros.svh"

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_load   = 7'b000_0011,
    op_imm    = 7'b001_0011,
    op_auipc  = 7'b001_0111,
    op_store  = 7'b010_0011,
    op_lui    = 7'b011_0111,
    op_jalr   = 7'b110_0111,
    op_jal    = 7'b110_1111,
    op_system = 7'b111_0011
  } opcode_e;

  // funct3 of loads and stores
  typedef enum logic [2:0] {
    size_byte   = 3'b000,
    size_half   = 3'b001,
    size_word   = 3'b010,
    size_byte_u = 3'b100,
    size_half_u = 3'b101
  } mem_size_e;

  // writeback source
  typedef enum logic [1:0] {
    wb_adder = 2'd0,
    wb_link  = 2'd1,  // pc + 4
    wb_load  = 2'd2
  } wb_sel_e;

  // load-store unit handshake FSM
  typedef enum logic [1:0] {
    lsu_idle,
    lsu_req,
    lsu_wait_ack_low
  } lsu_state_e;

  typedef struct packed {
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    mem_size_e              mem_size;
    wb_sel_e                wb_sel;
    logic                   use_pc;  // adder operand a is pc
    logic                   jump;
    logic                   halt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
  } ctrl_t;

  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
    logic [3:0]       wmask;
    logic             write;
  } dmem_req_t;

endpackage

/* verilog/rv_core_macros.svh */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// datapath and address width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h8000_0000

// integer register file
`define NUM_REGS 32
`define REG_ADDR_W 5

`endif
